// ==== include/fm_timer_settings.svh ====
`ifndef FM_TIMER_SETTINGS_SVH
`define FM_TIMER_SETTINGS_SVH

// Register map, first bank only
`define FM_REG_TIMER_A_HI 8'h24     // Value bits 9..2
`define FM_REG_TIMER_A_LO 8'h25     // Value bits 1..0
`define FM_REG_TIMER_B    8'h26
`define FM_REG_TIMER_CTRL 8'h27
`define FM_REG_DAC_DATA   8'h2A     // Code bits 8..1
`define FM_REG_DAC_CTRL   8'h2B
`define FM_REG_DAC_LSB    8'h2C     // Code bit 0

// Bit positions in the timer control register
`define FM_CTRL_LOAD_A 0
`define FM_CTRL_LOAD_B 1
`define FM_CTRL_IRQ_A  2
`define FM_CTRL_IRQ_B  3
`define FM_CTRL_CLR_A  4
`define FM_CTRL_CLR_B  5

// DAC bit positions
`define FM_DAC_EN_BIT  7            // In register 0x2B
`define FM_DAC_LSB_BIT 3            // In register 0x2C

// Timing
`define FM_BUSY_CYCLES 8            // Clock cycles busy after a data write
`define FM_TIMER_A_DIV 3            // Cen pulses per timer A step
`define FM_TIMER_B_DIV 48           // 16 times timer A

`endif

// ==== hw/fm_timer_pkg.sv ====
package fm_timer_pkg;

    typedef logic [7:0] bus_data_t;         // Host bus byte
    typedef logic [7:0] reg_addr_t;         // Internal register address
    typedef logic [9:0] timer_a_val_t;      // Timer A start value
    typedef logic [7:0] timer_b_val_t;      // Timer B start value
    typedef logic [8:0] pcm_code_t;         // Offset binary DAC code
    typedef logic signed [8:0] pcm_sample_t;

    // Timer control from register 0x27
    typedef struct packed {
        logic load_a;
        logic load_b;
        logic irq_en_a;
        logic irq_en_b;
        logic clr_a;    // One cycle pulse
        logic clr_b;    // One cycle pulse
    } timer_ctrl_t;

    typedef struct packed {
        timer_a_val_t value_a;
        timer_b_val_t value_b;
    } timer_cfg_t;

    // DAC path
    typedef struct packed {
        logic      dac_en;
        pcm_code_t code;
    } pcm_reg_t;

    // Busy window after a data write
    typedef enum logic {
        BUS_IDLE,
        BUS_BUSY
    } busy_state_t;

endpackage

// ==== hw/fm_bus_regs.sv ====
`include "fm_timer_settings.svh"

module fm_bus_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  fm_timer_pkg::bus_data_t   din,
    input  logic                      a0,
    input  logic                      cs_n,
    input  logic                      wr_n,
    output fm_timer_pkg::timer_ctrl_t ctrl,
    output fm_timer_pkg::timer_cfg_t  cfg,
    output fm_timer_pkg::pcm_reg_t    pcm,
    output logic                      busy
);

    localparam int cnt_w = $clog2(`FM_BUSY_CYCLES + 1);

    logic                      write;
    logic                      addr_wr;
    logic                      data_wr;
    fm_timer_pkg::reg_addr_t   addr_q;
    fm_timer_pkg::busy_state_t state;
    logic [cnt_w-1:0]          busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !a0;     // a0 low selects the address port
    assign data_wr = write && a0;

    // Register address stays until the next address write
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (addr_wr) begin
            addr_q <= din;
        end
    end

    // Data write decode
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
            cfg  <= '0;
            pcm  <= '0;
        end else begin
            ctrl.clr_a <= 1'b0;        // Flag resets last one cycle
            ctrl.clr_b <= 1'b0;
            if (data_wr) begin
                case (addr_q)
                    `FM_REG_TIMER_A_HI: begin
                        cfg.value_a[9:2] <= din;
                    end
                    `FM_REG_TIMER_A_LO: begin
                        cfg.value_a[1:0] <= din[1:0];
                    end
                    `FM_REG_TIMER_B: begin
                        cfg.value_b <= din;
                    end
                    `FM_REG_TIMER_CTRL: begin
                        ctrl.load_a   <= din[`FM_CTRL_LOAD_A];
                        ctrl.load_b   <= din[`FM_CTRL_LOAD_B];
                        ctrl.irq_en_a <= din[`FM_CTRL_IRQ_A];
                        ctrl.irq_en_b <= din[`FM_CTRL_IRQ_B];
                        ctrl.clr_a    <= din[`FM_CTRL_CLR_A];
                        ctrl.clr_b    <= din[`FM_CTRL_CLR_B];
                    end
                    `FM_REG_DAC_DATA: begin
                        pcm.code[8:1] <= din;
                    end
                    `FM_REG_DAC_CTRL: begin
                        pcm.dac_en <= din[`FM_DAC_EN_BIT];
                    end
                    `FM_REG_DAC_LSB: begin
                        pcm.code[0] <= din[`FM_DAC_LSB_BIT];
                    end
                    default: begin
                        // Registers outside the timer and DAC map are ignored
                    end
                endcase
            end
        end
    end

    // Busy window
    // Any data write starts or restarts the count, the host is never held off
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fm_timer_pkg::BUS_IDLE;
            busy_cnt <= '0;
        end else if (data_wr) begin
            state    <= fm_timer_pkg::BUS_BUSY;
            busy_cnt <= cnt_w'(`FM_BUSY_CYCLES - 1);
        end else begin
            case (state)
                fm_timer_pkg::BUS_BUSY: begin
                    if (busy_cnt == '0) begin
                        state <= fm_timer_pkg::BUS_IDLE;  // Last busy cycle
                    end else begin
                        busy_cnt <= busy_cnt - 1'b1;
                    end
                end
                default: begin
                    busy_cnt <= '0;
                end
            endcase
        end
    end

    assign busy = (state == fm_timer_pkg::BUS_BUSY);

endmodule

// ==== hw/fm_timer.sv ====
module fm_timer #(
    parameter int width = 10,
    parameter int div   = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cen,
    input  logic             load,
    input  logic [width-1:0] start_value,
    output logic             overflow
);

    localparam int presc_w = $clog2(div + 1);

    logic               load_q;
    logic               load_rise;
    logic               tick;
    logic [presc_w-1:0] presc;
    logic [width-1:0]   cnt;

    assign load_rise = load && !load_q;
    // One step every div cen pulses
    assign tick = cen && (presc == presc_w'(div - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load;
        end
    end

    // Prescaler restarts with every load so the period starts clean
    always_ff @(posedge clk) begin
        if (reset) begin
            presc <= '0;
        end else if (load_rise) begin
            presc <= '0;
        end else if (load && cen) begin
            presc <= tick ? '0 : presc + 1'b1;
        end
    end

    // Up counter, reloads from the start value when it wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (load_rise) begin
                cnt <= start_value;
            end else if (load && tick) begin
                if (&cnt) begin
                    cnt      <= start_value;
                    overflow <= 1'b1;   // Single cycle pulse
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/fm_status.sv ====
module fm_status (
    input  logic                      clk,
    input  logic                      reset,
    input  fm_timer_pkg::timer_ctrl_t ctrl,
    input  logic                      overflow_a,
    input  logic                      overflow_b,
    input  logic                      busy,
    input  fm_timer_pkg::pcm_reg_t    pcm,
    output fm_timer_pkg::bus_data_t   dout,
    output logic                      irq_n,
    output fm_timer_pkg::pcm_sample_t pcm_out
);

    logic flag_a;
    logic flag_b;

    // Clear has priority over a new overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_a <= 1'b0;
        end else if (ctrl.clr_a) begin
            flag_a <= 1'b0;
        end else if (overflow_a) begin
            flag_a <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_b <= 1'b0;
        end else if (ctrl.clr_b) begin
            flag_b <= 1'b0;
        end else if (overflow_b) begin
            flag_b <= 1'b1;
        end
    end

    // Flags stay set with the enable off, only the interrupt line is masked
    assign irq_n = !((flag_a && ctrl.irq_en_a) || (flag_b && ctrl.irq_en_b));

    // Status byte
    assign dout = {busy, 5'b0, flag_b, flag_a};

    // Offset binary to two's complement by flipping the sign bit
    always_comb begin
        if (pcm.dac_en) begin
            pcm_out = fm_timer_pkg::pcm_sample_t'({~pcm.code[8], pcm.code[7:0]});
        end else begin
            pcm_out = '0;   // DAC off is silence
        end
    end

endmodule

// ==== hw/fm_timer_top.sv ====
`include "fm_timer_settings.svh"

module fm_timer_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cen,      // Timer time base
    input  fm_timer_pkg::bus_data_t   din,
    input  logic                      a0,
    input  logic                      cs_n,
    input  logic                      wr_n,
    output fm_timer_pkg::bus_data_t   dout,
    output logic                      irq_n,
    output fm_timer_pkg::pcm_sample_t pcm_out
);

    fm_timer_pkg::timer_ctrl_t ctrl;
    fm_timer_pkg::timer_cfg_t  cfg;
    fm_timer_pkg::pcm_reg_t    pcm;
    logic                      busy;
    logic                      overflow_a;
    logic                      overflow_b;

    fm_bus_regs u_regs (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .din    ( din    ),
        .a0     ( a0     ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .ctrl   ( ctrl   ),
        .cfg    ( cfg    ),
        .pcm    ( pcm    ),
        .busy   ( busy   )
    );

    fm_timer #(.width(10), .div(`FM_TIMER_A_DIV)) u_timer_a (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cen         ( cen         ),
        .load        ( ctrl.load_a ),
        .start_value ( cfg.value_a ),
        .overflow    ( overflow_a  )
    );

    // Timer B runs 16 times slower
    fm_timer #(.width(8), .div(`FM_TIMER_B_DIV)) u_timer_b (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cen         ( cen         ),
        .load        ( ctrl.load_b ),
        .start_value ( cfg.value_b ),
        .overflow    ( overflow_b  )
    );

    fm_status u_status (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ctrl       ( ctrl       ),
        .overflow_a ( overflow_a ),
        .overflow_b ( overflow_b ),
        .busy       ( busy       ),
        .pcm        ( pcm        ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .pcm_out    ( pcm_out    )
    );

endmodule

// ==== tests/fm_timer_assert.sv ====
`include "fm_timer_settings.svh"

module fm_timer_assert (
    input logic                      clk,
    input logic                      reset,
    input fm_timer_pkg::bus_data_t   din,
    input logic                      a0,
    input logic                      cs_n,
    input logic                      wr_n,
    input fm_timer_pkg::bus_data_t   dout,
    input logic                      irq_n,
    input fm_timer_pkg::pcm_sample_t pcm_out
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                    addr_wr;
    logic                    data_wr;
    logic                    ctrl_wr;
    fm_timer_pkg::reg_addr_t addr_m;      // Mirrored host state
    fm_timer_pkg::pcm_code_t code_m;
    logic                    dac_en_m;
    logic                    en_a_m;
    logic                    en_b_m;
    logic [3:0]              busy_left;
    logic [8:0]              pcm_exp;
    int                      fail_count = 0;

    assign addr_wr = !cs_n && !wr_n && !a0;
    assign data_wr = !cs_n && !wr_n && a0;
    assign ctrl_wr = data_wr && (addr_m == `FM_REG_TIMER_CTRL);
    assign pcm_exp = dac_en_m ? {~code_m[8], code_m[7:0]} : 9'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_m    <= '0;
            code_m    <= '0;
            dac_en_m  <= 1'b0;
            en_a_m    <= 1'b0;
            en_b_m    <= 1'b0;
            busy_left <= '0;
        end else begin
            if (addr_wr) addr_m <= din;
            if (ctrl_wr) begin
                en_a_m <= din[`FM_CTRL_IRQ_A];
                en_b_m <= din[`FM_CTRL_IRQ_B];
            end
            if (data_wr && addr_m == `FM_REG_DAC_DATA) code_m[8:1] <= din;
            if (data_wr && addr_m == `FM_REG_DAC_LSB) code_m[0] <= din[`FM_DAC_LSB_BIT];
            if (data_wr && addr_m == `FM_REG_DAC_CTRL) dac_en_m <= din[`FM_DAC_EN_BIT];
            if (data_wr) busy_left <= 4'(`FM_BUSY_CYCLES);   // Restarts on every data write
            else if (busy_left != 0) busy_left <= busy_left - 1'b1;
        end
    end

    a_reset_hold: assert property (@(posedge clk)
        reset |=> (irq_n && dout == '0 && pcm_out == '0))
        else begin
            $error("outputs not at rest during reset");
            fail_count++;
        end
    a_reset_release: assert property (@(posedge clk)
        $fell(reset) |-> ##1 (irq_n && dout == '0 && pcm_out == '0))
        else begin
            $error("outputs not at rest after reset");
            fail_count++;
        end
    a_busy: assert property (@(posedge clk) disable iff (reset) dout[7] == (busy_left != 0))
        else begin
            $error("busy bit does not match the data write window");
            fail_count++;
        end
    a_pcm: assert property (@(posedge clk) disable iff (reset) $unsigned(pcm_out) == pcm_exp)
        else begin
            $error("pcm_out does not match the written DAC code");
            fail_count++;
        end
    a_clear_a: assert property (@(posedge clk) disable iff (reset)
        ctrl_wr && din[`FM_CTRL_CLR_A] |-> ##2 !dout[0])
        else begin
            $error("timer A flag still set after a clear");
            fail_count++;
        end
    a_clear_b: assert property (@(posedge clk) disable iff (reset)
        ctrl_wr && din[`FM_CTRL_CLR_B] |-> ##2 !dout[1])
        else begin
            $error("timer B flag still set after a clear");
            fail_count++;
        end
    // Flag A only drops because of a clear
    a_hold_a: assert property (@(posedge clk) disable iff (reset)
        $fell(dout[0]) |-> $past(ctrl_wr && din[`FM_CTRL_CLR_A], 2))
        else begin
            $error("timer A flag dropped without a clear");
            fail_count++;
        end
    a_irq: assert property (@(posedge clk) disable iff (reset)
        irq_n == !((dout[0] && en_a_m) || (dout[1] && en_b_m)))
        else begin
            $error("irq_n does not follow flags and enables");
            fail_count++;
        end

endmodule

bind fm_timer_top fm_timer_assert u_chk (
    .clk     ( clk     ),
    .reset   ( reset   ),
    .din     ( din     ),
    .a0      ( a0      ),
    .cs_n    ( cs_n    ),
    .wr_n    ( wr_n    ),
    .dout    ( dout    ),
    .irq_n   ( irq_n   ),
    .pcm_out ( pcm_out )
);

// ==== tests/fm_timer_tb.sv ====
`include "fm_timer_settings.svh"

module fm_timer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int len_timer_a    = 1024 * `FM_TIMER_A_DIV;
    localparam int len_timer_b    = 256 * `FM_TIMER_B_DIV;
    localparam int len_other      = 2000;   // Reset, busy, PCM and interrupt tests
    localparam int timeout_cycles = 3 * (len_timer_a + len_timer_b + len_other);

    logic clk = 1'b0;
    logic reset;
    logic cen;
    logic a0;
    logic cs_n;
    logic wr_n;
    logic irq_n;
    fm_timer_pkg::bus_data_t   din;
    fm_timer_pkg::bus_data_t   dout;
    fm_timer_pkg::pcm_sample_t pcm_out;
    int unsigned seed = 95;
    int checks = 0;
    int errors = 0;
    int test_num = 0;
    int mark = 0;
    int cycle_count = 0;

    fm_timer_top uut (
        .clk(clk), .reset(reset), .cen(cen), .din(din), .a0(a0), .cs_n(cs_n),
        .wr_n(wr_n), .dout(dout), .irq_n(irq_n), .pcm_out(pcm_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: no result after %0d clock cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) & 32'h7fff;
    endfunction

    // Address cycle then data cycle up to the edge that takes the data
    task automatic write_reg(input fm_timer_pkg::reg_addr_t addr,
                             input fm_timer_pkg::bus_data_t value);
        @(posedge clk);
        din  <= addr;
        a0   <= 1'b0;
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(posedge clk);
        din <= value;
        a0  <= 1'b1;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        a0   <= 1'b0;
    endtask

    task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input string what, input int got, input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("Fail %0t ns: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("Test %0d %s finished with %0d errors", test_num, name,
                 errors + uut.u_chk.fail_count - mark);
        mark = errors + uut.u_chk.fail_count;
    endtask

    task automatic check_rest();
        check_value("dout", {8'b0, dout}, 16'd0);
        check_value("irq_n", {15'b0, irq_n}, 16'd1);
        check_value("pcm_out", {7'b0, pcm_out}, 16'd0);
    endtask

    task automatic wait_flag(input int bit_pos, output int cycles);
        cycles = 0;
        while (!dout[bit_pos]) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        fm_timer_pkg::pcm_code_t code;
        fm_timer_pkg::bus_data_t ctrl_byte;
        logic [8:0] pcm_exp;
        logic       en;
        int         v;
        int         got;
        int unsigned bits;
        reset <= 1'b1;
        cen   <= 1'b1;
        din   <= '0;
        a0    <= 1'b0;
        cs_n  <= 1'b1;
        wr_n  <= 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_rest();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_rest();
        report_test("reset");

        for (int i = 0; i < 6; i++) begin
            write_reg(8'h30 + 8'(next_rand() % 16), 8'(next_rand()));   // Unmapped registers
            @(negedge clk);
            check_value("busy bit", {15'b0, dout[7]}, 16'd1);
            repeat (next_rand() % 4) @(posedge clk);
        end
        repeat (`FM_BUSY_CYCLES + 1) @(posedge clk);
        @(posedge clk);
        din  <= 8'h31;
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        @(negedge clk);
        check_value("busy bit after address write", {15'b0, dout[7]}, 16'd0);
        report_test("busy");

        for (int i = 0; i < 8; i++) begin
            code = 9'(next_rand());
            en   = (next_rand() % 4) != 0;
            write_reg(`FM_REG_DAC_DATA, code[8:1]);
            write_reg(`FM_REG_DAC_LSB, {4'b0, code[0], 3'b0});
            write_reg(`FM_REG_DAC_CTRL, {en, 7'b0});
            pcm_exp = en ? {~code[8], code[7:0]} : 9'd0;   // Sign bit flipped
            @(negedge clk);
            check_value("pcm_out", {7'b0, pcm_out}, {7'b0, pcm_exp});
            repeat (next_rand() % 4) @(posedge clk);
        end
        report_test("pcm");

        v = int'(next_rand() % 768);
        write_reg(`FM_REG_TIMER_A_HI, 8'(v >> 2));
        write_reg(`FM_REG_TIMER_A_LO, 8'(v & 3));
        write_reg(`FM_REG_TIMER_CTRL, 8'(1 << `FM_CTRL_LOAD_A));
        wait_flag(0, got);
        // Control register, load edge and flag add a few cycles
        check_range("timer A flag delay", got, (1024 - v) * `FM_TIMER_A_DIV,
                    (1024 - v) * `FM_TIMER_A_DIV + 3);
        repeat (4) @(negedge clk);
        check_value("timer A flag held", {15'b0, dout[0]}, 16'd1);
        write_reg(`FM_REG_TIMER_CTRL, 8'((1 << `FM_CTRL_LOAD_A) | (1 << `FM_CTRL_CLR_A)));
        repeat (2) @(negedge clk);
        check_value("timer A flag after clear", {15'b0, dout[0]}, 16'd0);
        write_reg(`FM_REG_TIMER_CTRL, 8'h00);
        report_test("timer_a");

        v = 128 + int'(next_rand() % 128);
        write_reg(`FM_REG_TIMER_B, 8'(v));
        write_reg(`FM_REG_TIMER_CTRL, 8'((1 << `FM_CTRL_LOAD_B) | (1 << `FM_CTRL_IRQ_B)));
        got = 0;
        while (!dout[1]) begin
            @(posedge clk);
            cen <= (next_rand() % 4) != 0;         // About a quarter of cycles without cen
            @(negedge clk);
            if (!dout[1] && cen) got++;
        end
        @(posedge clk);
        cen <= 1'b1;
        check_range("timer B cen pulses", got, (256 - v) * `FM_TIMER_B_DIV,
                    (256 - v) * `FM_TIMER_B_DIV + 2);
        write_reg(`FM_REG_TIMER_CTRL, 8'((1 << `FM_CTRL_LOAD_B) | (1 << `FM_CTRL_CLR_B)));
        repeat (2) @(negedge clk);
        check_value("timer B flag after clear", {15'b0, dout[1]}, 16'd0);
        write_reg(`FM_REG_TIMER_CTRL, 8'h00);
        report_test("timer_b");

        write_reg(`FM_REG_TIMER_A_HI, 8'(1000 >> 2));   // Short period for A
        write_reg(`FM_REG_TIMER_A_LO, 8'(1000 & 3));
        for (int r = 0; r < 4; r++) begin
            bits = next_rand();
            ctrl_byte = '0;
            ctrl_byte[`FM_CTRL_LOAD_A] = 1'b1;
            ctrl_byte[`FM_CTRL_IRQ_A]  = (r == 0) || bits[3];
            ctrl_byte[`FM_CTRL_IRQ_B]  = bits[4];
            ctrl_byte[`FM_CTRL_CLR_A]  = (r != 0);
            write_reg(`FM_REG_TIMER_CTRL, ctrl_byte);
            repeat (2) @(negedge clk);
            // Flag A is clear at this point
            check_value("irq_n after enable write", {15'b0, irq_n}, 16'd1);
            wait_flag(0, got);
            check_value("irq_n with flag A set", {15'b0, irq_n},
                        {15'b0, !ctrl_byte[`FM_CTRL_IRQ_A]});
        end
        write_reg(`FM_REG_TIMER_CTRL, 8'((1 << `FM_CTRL_CLR_A) | (1 << `FM_CTRL_CLR_B) |
                                         (1 << `FM_CTRL_IRQ_A) | (1 << `FM_CTRL_IRQ_B)));
        repeat (2) @(negedge clk);
        check_value("irq_n after clear", {15'b0, irq_n}, 16'd1);
        report_test("irq");

        $display("Checks: %0d run, %0d wrong values, %0d assertion failures",
                 checks, errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== fm_timer.f ====
+incdir+include
hw/fm_timer_pkg.sv
hw/fm_bus_regs.sv
hw/fm_timer.sv
hw/fm_status.sv
hw/fm_timer_top.sv
tests/fm_timer_assert.sv
tests/fm_timer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := fm_timer_tb
FILELIST  := fm_timer.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := Test completed successfully
SOURCES   := $(wildcard hw/*.sv tests/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
